// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench and RTL with Verilator, then run it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_riscv_alu_core -f verilog.f -o tb_riscv_alu_core; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_riscv_alu_core)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// ==== sim/core_asserts.sv ====
////////////////////
// Report output protocol checks
// Bound into every riscv_alu_core instance
////////////////////
`timescale 1ns/1ns
`default_nettype none

module core_asserts (
  input wire                 clock,
  input wire                 i_rst_n,
  input wire                 i_instr_valid,
  input wire                 o_report_valid,
  input core_pkg::reg_addr_t o_report_reg
);
  import core_pkg::*;

  report_in_window: assert property (@(posedge clock) disable iff (!i_rst_n)
    o_report_valid |-> (o_report_reg >= REPORT_REG_LO && o_report_reg <= REPORT_REG_HI))
    else $error("report for x%0d lies outside the report window", o_report_reg);

  // Report is registered two edges after the strobe and seen one edge later
  report_after_strobe: assert property (@(posedge clock) disable iff (!i_rst_n)
    o_report_valid |-> $past(i_instr_valid, 3))
    else $error("report without a strobe two edges before it was registered");

  report_low_after_reset: assert property (@(posedge clock)
    $rose(i_rst_n) |-> !o_report_valid)
    else $error("report valid high in the cycle after reset");

endmodule

bind riscv_alu_core core_asserts u_core_asserts (
  .clock          (clock),
  .i_rst_n        (i_rst_n),
  .i_instr_valid  (i_instr_valid),
  .o_report_valid (o_report_valid),
  .o_report_reg   (o_report_reg)
);

`default_nettype wire

// ==== sim/tb_riscv_alu_core.sv ====
////////////////////
// Random instruction stream from a 16-bit Galois LFSR, fixed seed
// First 32 instructions load every register so model and DUT agree
// Model runs each instruction at issue and queues expected reports
////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_riscv_alu_core;

  localparam int NUM_DIRECTED   = 8;
  localparam int NUM_RANDOM     = 400;
  localparam int RESET_CYCLES   = 4;
  localparam int NUM_PLANNED    = 32 + NUM_DIRECTED + NUM_RANDOM;
  localparam int TIMEOUT_CYCLES = 3 * NUM_PLANNED + RESET_CYCLES + 20;
  localparam logic [6:0] OPC_R = 7'b0110011;
  localparam logic [6:0] OPC_I = 7'b0010011;
  localparam logic [6:0] OPC_U = 7'b0110111;

  logic        clock = 1'b0;
  logic        i_rst_n;
  logic        i_instr_valid;
  logic [31:0] i_instr;
  logic        o_report_valid;
  logic [4:0]  o_report_reg;
  logic [31:0] o_report_data;

  logic [15:0] lfsr_state = 16'd15115;
  logic [31:0] model_regs [32];
  logic [4:0]  recent [4];
  logic [1:0]  recent_ptr = 2'd0;
  logic [31:0] directed [NUM_DIRECTED];
  logic [4:0]  exp_reg [$];
  logic [31:0] exp_data [$];
  int          exp_edge [$];
  string       exp_name [$];
  int          edge_count = 0;
  int          errors = 0;
  int          n;

  riscv_alu_core UUT (
    .clock          (clock),
    .i_rst_n        (i_rst_n),
    .i_instr_valid  (i_instr_valid),
    .i_instr        (i_instr),
    .o_report_valid (o_report_valid),
    .o_report_reg   (o_report_reg),
    .o_report_data  (o_report_data)
  );

  always #10 clock = ~clock;

  // Taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < count; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  // RV32I arithmetic for OP and OP-IMM
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $unsigned($signed(a) >>> b[4:0]);
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic model_exec(input logic [31:0] ins, input string name);
    logic [4:0]  rd;
    logic [31:0] res;
    logic        writes;
    rd     = ins[11:7];
    res    = '0;
    writes = 1'b1;
    case (ins[6:0])
      OPC_R: res = alu_ref(ins[14:12], ins[30], model_regs[ins[19:15]], model_regs[ins[24:20]]);
      OPC_I: res = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, model_regs[ins[19:15]],
                           {{20{ins[31]}}, ins[31:20]});
      OPC_U: res = {ins[31:12], 12'd0};
      default: writes = 1'b0;
    endcase
    if (writes && rd != 5'd0) begin
      model_regs[rd]     = res;
      recent[recent_ptr] = rd;
      recent_ptr         = recent_ptr + 2'd1;
      if (rd >= 5'd10 && rd <= 5'd17) begin
        exp_reg.push_back(rd);
        exp_data.push_back(res);
        // Drive edge plus one to sample, plus two to the report
        exp_edge.push_back(edge_count + 4);
        exp_name.push_back(name);
      end
    end
  endtask

  task automatic issue(input logic [31:0] ins, input string name);
    @(posedge clock);
    i_instr_valid <= 1'b1;
    i_instr       <= ins;
    model_exec(ins, name);
  endtask

  // Junk on the bus while the strobe is low
  task automatic idle_cycle();
    @(posedge clock);
    i_instr_valid <= 1'b0;
    i_instr       <= take_bits(32);
  endtask

  function automatic logic [4:0] pick_src();
    if (take_bits(1) != 0) begin
      return recent[2'(take_bits(2))];
    end
    return 5'(take_bits(5));
  endfunction

  function automatic logic [31:0] random_instr();
    logic [2:0]  kind;
    logic [2:0]  f3;
    logic        alt;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [6:0]  opc;
    kind = 3'(take_bits(3));
    f3   = 3'(take_bits(3));
    alt  = (take_bits(1) != 0);
    case (take_bits(2))
      0: rd = 5'd10 + 5'(take_bits(3));
      1: rd = recent[2'(take_bits(2))];
      default: rd = 5'(take_bits(5));
    endcase
    rs1 = pick_src();
    rs2 = pick_src();
    imm = 12'(take_bits(12));
    case (kind)
      3'd0, 3'd1, 3'd2: return {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'd0, rs2, rs1, f3, rd,
                                OPC_R};
      3'd3, 3'd4, 3'd5: begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          imm = {1'b0, alt && f3 == 3'd5, 5'd0, imm[4:0]};
        end
        return {imm, rs1, f3, rd, OPC_I};
      end
      3'd6: return {imm, rs1, f3, rd, OPC_U};
      default: begin
        // Load, store, branch and JAL all become bubbles
        case (f3[1:0])
          2'd0: opc = 7'b0000011;
          2'd1: opc = 7'b0100011;
          2'd2: opc = 7'b1100011;
          default: opc = 7'b1101111;
        endcase
        return {imm, rs1, f3, rd, opc};
      end
    endcase
  endfunction

  always @(posedge clock) begin
    edge_count <= edge_count + 1;
    if (edge_count >= TIMEOUT_CYCLES) begin
      $display("Timeout, run still busy after %0d cycles", edge_count);
      $display("Summary: %0d errors", errors);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // Outputs settle well before the falling edge
  always @(negedge clock) begin
    if (edge_count >= 1) begin
      assert (!$isunknown(o_report_valid)) else begin
        errors++;
        $display("Report valid is unknown at edge %0d", edge_count);
      end
    end
    if (o_report_valid === 1'b1) begin
      if (exp_reg.size() == 0) begin
        errors++;
        $display("Unexpected report for x%0d at edge %0d", o_report_reg, edge_count);
      end else begin
        assert (o_report_reg == exp_reg[0]) else begin
          errors++;
          $display("CHECK FAILED %s: register expected x%0d actual x%0d",
                   exp_name[0], exp_reg[0], o_report_reg);
        end
        assert (o_report_data == exp_data[0]) else begin
          errors++;
          $display("CHECK FAILED %s: data for x%0d expected %08h actual %08h",
                   exp_name[0], exp_reg[0], exp_data[0], o_report_data);
        end
        assert (edge_count == exp_edge[0]) else begin
          errors++;
          $display("CHECK FAILED %s: report edge expected %0d actual %0d",
                   exp_name[0], exp_edge[0], edge_count);
        end
        void'(exp_reg.pop_front());
        void'(exp_data.pop_front());
        void'(exp_edge.pop_front());
        void'(exp_name.pop_front());
      end
    end else if (exp_edge.size() != 0 && exp_edge[0] <= edge_count) begin
      errors++;
      $display("Report for x%0d due at edge %0d did not arrive", exp_reg[0], exp_edge[0]);
      void'(exp_reg.pop_front());
      void'(exp_data.pop_front());
      void'(exp_edge.pop_front());
      void'(exp_name.pop_front());
    end
  end

  initial begin
    i_rst_n       = 1'b0;
    i_instr_valid = 1'b0;
    i_instr       = '0;
    model_regs[0] = '0;
    for (n = 0; n < 4; n++) begin
      recent[n] = 5'(10 + n);
    end
    // Chains at distance one and two, x0 writes and a bubble
    directed[0] = {12'hFF9, 5'd0, 3'd0, 5'd10, OPC_I};
    directed[1] = {12'd3, 5'd10, 3'd0, 5'd11, OPC_I};
    directed[2] = {7'd0, 5'd11, 5'd10, 3'd0, 5'd12, OPC_R};
    directed[3] = {7'h20, 5'd11, 5'd12, 3'd5, 5'd13, OPC_R};
    directed[4] = {12'd123, 5'd0, 3'd0, 5'd0, OPC_I};
    directed[5] = {7'd0, 5'd0, 5'd0, 3'd0, 5'd14, OPC_R};
    directed[6] = {12'd0, 5'd0, 3'd2, 5'd11, 7'b0000011};
    directed[7] = {7'd0, 5'd11, 5'd12, 3'd3, 5'd15, OPC_R};

    repeat (RESET_CYCLES) @(posedge clock);
    i_rst_n <= 1'b1;

    for (n = 0; n < 32; n++) begin
      issue({12'(take_bits(12)), 5'd0, 3'd0, 5'(n), OPC_I}, "init");
    end
    for (n = 0; n < NUM_DIRECTED; n++) begin
      issue(directed[n], "forward");
    end
    for (n = 0; n < NUM_RANDOM; n++) begin
      // Strobe in about 11 of 16 cycles
      while (take_bits(4) >= 11) begin
        idle_cycle();
      end
      issue(random_instr(), "random");
    end
    idle_cycle();
    repeat (6) @(posedge clock);

    if (exp_reg.size() != 0) begin
      errors++;
      $display("%0d expected reports never arrived", exp_reg.size());
    end
    $display("Summary: %0d errors", errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/core_pkg.sv ====
////////////////////
// Shared definitions for the RV32 ALU pipeline
// Only OP, OP-IMM and LUI opcodes are decoded, others become bubbles
// Report window covers the argument registers a0 to a7
////////////////////
`default_nettype none

package core_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [31:0]     instr_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;

  // Supported major opcodes
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;

  // funct3 encodings shared by OP and OP-IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B    // LUI, immediate goes straight through
  } alu_op_t;

  // Where an operand comes from
  typedef enum logic [1:0] {
    FWD_REGFILE,
    FWD_EX,
    FWD_WB
  } fwd_sel_t;

  // Writes to these registers are reported
  localparam reg_addr_t REPORT_REG_LO = 5'd10;
  localparam reg_addr_t REPORT_REG_HI = 5'd17;

endpackage

`default_nettype wire

// ==== source/decode_control.sv ====
////////////////////
// Decode stage taking one instruction per strobe with no back-pressure
// Execute hits capture the live ALU result here
// Writeback hits are resolved later in execute
////////////////////
`timescale 1ns/1ns
`default_nettype none

module decode_control (
  input  wire                 clock,
  input  wire                 i_rst_n,
  input  wire                 i_instr_valid,
  input  core_pkg::instr_t    i_instr,
  input  core_pkg::xlen_t     i_ex_result,
  stage_if.producer           ex_bus,
  stage_if.consumer           wb_bus,
  output core_pkg::reg_addr_t o_rs1,
  output core_pkg::reg_addr_t o_rs2,
  input  core_pkg::xlen_t     i_rs1_data,
  input  core_pkg::xlen_t     i_rs2_data
);
  import core_pkg::*;

  opcode_t   opcode;
  funct3_t   funct3;
  reg_addr_t rd;
  logic      alt;
  alu_op_t   alu_op;
  xlen_t     imm;
  logic      use_imm;
  logic      reg_write;
  fwd_sel_t  sel_a;
  fwd_sel_t  sel_b;

  function automatic alu_op_t alu_from_funct3(input funct3_t f3, input logic sub_sra);
    case (f3)
      F3_ADD_SUB: return sub_sra ? ALU_SUB : ALU_ADD;
      F3_SLL:     return ALU_SLL;
      F3_SLT:     return ALU_SLT;
      F3_SLTU:    return ALU_SLTU;
      F3_XOR:     return ALU_XOR;
      F3_SRL_SRA: return sub_sra ? ALU_SRA : ALU_SRL;
      F3_OR:      return ALU_OR;
      default:    return ALU_AND;
    endcase
  endfunction

  // Youngest producer wins
  function automatic fwd_sel_t pick_source(input reg_addr_t rs);
    if (ex_bus.valid && ex_bus.reg_write && ex_bus.rd == rs) begin
      return FWD_EX;
    end
    if (wb_bus.valid && wb_bus.reg_write && wb_bus.rd == rs) begin
      return FWD_WB;
    end
    return FWD_REGFILE;
  endfunction

  assign opcode = i_instr[6:0];
  assign rd     = i_instr[11:7];
  assign funct3 = i_instr[14:12];
  assign alt    = i_instr[30];
  assign o_rs1  = i_instr[19:15];
  assign o_rs2  = i_instr[24:20];

  always_comb begin
    alu_op    = ALU_ADD;
    imm       = {{20{i_instr[31]}}, i_instr[31:20]};
    use_imm   = 1'b0;
    reg_write = 1'b0;
    case (opcode)
      OPC_OP: begin
        alu_op    = alu_from_funct3(funct3, alt);
        reg_write = 1'b1;
      end
      OPC_OP_IMM: begin
        // Bit 30 only selects SRAI since ADDI has no subtract form
        alu_op    = alu_from_funct3(funct3, alt && funct3 == F3_SRL_SRA);
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      OPC_LUI: begin
        alu_op    = ALU_PASS_B;
        imm       = {i_instr[31:12], 12'b0};
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      default: begin
        reg_write = 1'b0;
      end
    endcase
    // x0 is never written
    if (rd == '0) begin
      reg_write = 1'b0;
    end
  end

  always_comb begin
    sel_a = pick_source(o_rs1);
    sel_b = pick_source(o_rs2);
  end

  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      ex_bus.valid     <= 1'b0;
      ex_bus.reg_write <= 1'b0;
    end else begin
      ex_bus.valid     <= i_instr_valid;
      ex_bus.reg_write <= reg_write;
    end
  end

  always_ff @(posedge clock) begin
    ex_bus.rd      <= rd;
    ex_bus.alu_op  <= alu_op;
    ex_bus.imm     <= imm;
    ex_bus.use_imm <= use_imm;
    ex_bus.sel_a   <= sel_a;
    ex_bus.sel_b   <= sel_b;
    ex_bus.op_a    <= (sel_a == FWD_EX) ? i_ex_result : i_rs1_data;
    ex_bus.op_b    <= (sel_b == FWD_EX) ? i_ex_result : i_rs2_data;
  end

  assign ex_bus.result = '0;

endmodule

`default_nettype wire

// ==== source/execute_unit.sv ====
////////////////////
// Execute stage, single-cycle ALU
// Writeback-stage sources come from the copy of the last written value
// Shift amounts use the low five bits only
////////////////////
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
  input  wire             clock,
  input  wire             i_rst_n,
  stage_if.consumer       ex_bus,
  stage_if.producer       wb_bus,
  output core_pkg::xlen_t o_result
);
  import core_pkg::*;

  xlen_t    retired_result;
  xlen_t    opnd_a;
  xlen_t    opnd_b;
  logic [4:0] shamt;
  xlen_t    result;

  function automatic xlen_t resolve(input fwd_sel_t sel, input xlen_t decoded,
                                    input xlen_t retired);
    // Execute hits were already captured at decode
    if (sel == FWD_WB) begin
      return retired;
    end
    return decoded;
  endfunction

  assign opnd_a = resolve(ex_bus.sel_a, ex_bus.op_a, retired_result);
  assign opnd_b = ex_bus.use_imm ? ex_bus.imm :
                  resolve(ex_bus.sel_b, ex_bus.op_b, retired_result);
  assign shamt  = opnd_b[4:0];

  always_comb begin
    case (ex_bus.alu_op)
      ALU_ADD:    result = opnd_a + opnd_b;
      ALU_SUB:    result = opnd_a - opnd_b;
      ALU_SLL:    result = opnd_a << shamt;
      ALU_SLT:    result = {31'b0, $signed(opnd_a) < $signed(opnd_b)};
      ALU_SLTU:   result = {31'b0, opnd_a < opnd_b};
      ALU_XOR:    result = opnd_a ^ opnd_b;
      ALU_SRL:    result = opnd_a >> shamt;
      ALU_SRA:    result = xlen_t'($signed(opnd_a) >>> shamt);
      ALU_OR:     result = opnd_a | opnd_b;
      ALU_AND:    result = opnd_a & opnd_b;
      ALU_PASS_B: result = opnd_b;
      default:    result = '0;
    endcase
  end

  assign o_result = result;

  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      wb_bus.valid     <= 1'b0;
      wb_bus.reg_write <= 1'b0;
    end else begin
      wb_bus.valid     <= ex_bus.valid;
      wb_bus.reg_write <= ex_bus.reg_write;
    end
  end

  always_ff @(posedge clock) begin
    wb_bus.rd      <= ex_bus.rd;
    wb_bus.result  <= result;
    // Value that writeback commits on this same edge
    retired_result <= wb_bus.result;
  end

  // Operand fields are not carried past execute
  assign wb_bus.alu_op  = ALU_ADD;
  assign wb_bus.op_a    = '0;
  assign wb_bus.op_b    = '0;
  assign wb_bus.sel_a   = FWD_REGFILE;
  assign wb_bus.sel_b   = FWD_REGFILE;
  assign wb_bus.imm     = '0;
  assign wb_bus.use_imm = 1'b0;

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
////////////////////
// 32 x 32 register file, two async reads, one sync write
// x0 reads as zero, contents are not reset
////////////////////
`timescale 1ns/1ns
`default_nettype none

module register_file (
  input  wire                 clock,
  input  core_pkg::reg_addr_t i_rs1,
  input  core_pkg::reg_addr_t i_rs2,
  output core_pkg::xlen_t     o_rs1_data,
  output core_pkg::xlen_t     o_rs2_data,
  input  wire                 i_we,
  input  core_pkg::reg_addr_t i_rd,
  input  core_pkg::xlen_t     i_wdata
);
  import core_pkg::*;

  xlen_t regs [NUM_REGS];

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

  always_ff @(posedge clock) begin
    if (i_we && i_rd != '0) begin
      regs[i_rd] <= i_wdata;
    end
  end

endmodule

`default_nettype wire

// ==== source/riscv_alu_core.sv ====
////////////////////
// Three-stage RV32 ALU core, decode, execute, writeback
// i_instr is taken whenever i_instr_valid is high, never refused
// Report lags the sampling edge by two cycles
////////////////////
`timescale 1ns/1ns
`default_nettype none

module riscv_alu_core (
  input  wire                 clock,
  input  wire                 i_rst_n,
  input  wire                 i_instr_valid,
  input  core_pkg::instr_t    i_instr,
  output logic                o_report_valid,
  output core_pkg::reg_addr_t o_report_reg,
  output core_pkg::xlen_t     o_report_data
);
  import core_pkg::*;

  reg_addr_t rs1;
  reg_addr_t rs2;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  xlen_t     ex_result;
  logic      rf_we;
  reg_addr_t rf_rd;
  xlen_t     rf_wdata;

  stage_if ex_bus ();
  stage_if wb_bus ();

  decode_control u_decode (
    .clock         (clock),
    .i_rst_n       (i_rst_n),
    .i_instr_valid (i_instr_valid),
    .i_instr       (i_instr),
    .i_ex_result   (ex_result),
    .ex_bus        (ex_bus.producer),
    .wb_bus        (wb_bus.consumer),
    .o_rs1         (rs1),
    .o_rs2         (rs2),
    .i_rs1_data    (rs1_data),
    .i_rs2_data    (rs2_data)
  );

  register_file u_regfile (
    .clock      (clock),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_we       (rf_we),
    .i_rd       (rf_rd),
    .i_wdata    (rf_wdata)
  );

  execute_unit u_execute (
    .clock    (clock),
    .i_rst_n  (i_rst_n),
    .ex_bus   (ex_bus.consumer),
    .wb_bus   (wb_bus.producer),
    .o_result (ex_result)
  );

  writeback_unit u_writeback (
    .clock          (clock),
    .i_rst_n        (i_rst_n),
    .wb_bus         (wb_bus.consumer),
    .o_we           (rf_we),
    .o_rd           (rf_rd),
    .o_wdata        (rf_wdata),
    .o_report_valid (o_report_valid),
    .o_report_reg   (o_report_reg),
    .o_report_data  (o_report_data)
  );

endmodule

`default_nettype wire

// ==== source/stage_if.sv ====
////////////////////
// One pipeline stage bundle
// wb_bus uses only valid, rd, reg_write and result
////////////////////
`timescale 1ns/1ns
`default_nettype none

interface stage_if;
  import core_pkg::*;

  logic      valid;
  reg_addr_t rd;
  logic      reg_write;
  alu_op_t   alu_op;
  xlen_t     op_a;
  xlen_t     op_b;
  fwd_sel_t  sel_a;
  fwd_sel_t  sel_b;
  xlen_t     imm;
  logic      use_imm;
  xlen_t     result;

  modport producer (
    output valid, rd, reg_write, alu_op,
    output op_a, op_b, sel_a, sel_b, imm, use_imm,
    output result
  );

  modport consumer (
    input valid, rd, reg_write, alu_op,
    input op_a, op_b, sel_a, sel_b, imm, use_imm,
    input result
  );

endinterface

`default_nettype wire

// ==== source/writeback_unit.sv ====
////////////////////
// Writeback stage and peripheral report
// Report appears one cycle after the register write
////////////////////
`timescale 1ns/1ns
`default_nettype none

module writeback_unit (
  input  wire                 clock,
  input  wire                 i_rst_n,
  stage_if.consumer           wb_bus,
  output logic                o_we,
  output core_pkg::reg_addr_t o_rd,
  output core_pkg::xlen_t     o_wdata,
  output logic                o_report_valid,
  output core_pkg::reg_addr_t o_report_reg,
  output core_pkg::xlen_t     o_report_data
);
  import core_pkg::*;

  logic in_window;

  assign o_we    = wb_bus.valid && wb_bus.reg_write;
  assign o_rd    = wb_bus.rd;
  assign o_wdata = wb_bus.result;

  // a0 to a7
  assign in_window = (wb_bus.rd >= REPORT_REG_LO) && (wb_bus.rd <= REPORT_REG_HI);

  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      o_report_valid <= 1'b0;
    end else begin
      o_report_valid <= o_we && in_window;
    end
  end

  always_ff @(posedge clock) begin
    o_report_reg  <= wb_bus.rd;
    o_report_data <= wb_bus.result;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/core_pkg.sv
source/stage_if.sv
source/register_file.sv
source/decode_control.sv
source/execute_unit.sv
source/writeback_unit.sv
source/riscv_alu_core.sv
sim/core_asserts.sv
sim/tb_riscv_alu_core.sv
